/* all.f */
+incdir+bench
src/dispatch_pkg.sv
src/cpu_pool.sv
src/thread_table.sv
src/dispatch_ctl.sv
src/cpu_dispatcher.sv
bench/tb_cpu_dispatcher.sv

/* Bender.yml */
package:
  name: cpu_dispatcher

sources:
  - src/dispatch_pkg.sv
  - src/cpu_pool.sv
  - src/thread_table.sv
  - src/dispatch_ctl.sv
  - src/cpu_dispatcher.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_cpu_dispatcher.sv

/* bench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // one-cycle message, returns at the edge that samples it
  task automatic send_msg(input msg_kind_t kind, input cpu_id_t cpu,
                          input proc_addr_t addr, input thread_id_t thread);
    @(posedge clk);
    msg_valid <= 1'b1;
    msg_kind <= kind;
    msg_cpu <= cpu;
    msg_addr <= addr;
    msg_thread <= thread;
    @(posedge clk);
    msg_valid <= 1'b0;
  endtask

  // reply must show up 2 cycles after the sampling edge
  task automatic await_reply(input rsp_kind_t kind, input thread_id_t thread);
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) fail_run("no reply to a fork or stop within the timeout");
    end while (!rsp_valid);
    check_value("reply latency", waited, 2);
    check_value("rsp_kind", rsp_kind, kind);
    check_value("rsp_thread", rsp_thread, thread);
  endtask

  task automatic return_credit();
    @(posedge clk);
    credit_return <= 1'b1;
    @(posedge clk);
    credit_return <= 1'b0;
  endtask

  task automatic await_dispatches(input int target);
    int waited;
    waited = 0;
    while (disp_count < target) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) fail_run("expected dispatch did not arrive in time");
    end
  endtask

  // empty table, nothing moves
  task automatic test_idle();
    repeat (20) begin
      @(posedge clk);
      check_value("rsp_valid", rsp_valid, 1'b0);
      check_value("disp_valid", disp_valid, 1'b0);
    end
  endtask

  task automatic test_fork_fill();
    for (int i = 0; i < THREAD_SLOTS; i++) begin
      send_msg(MSG_FORK, '0, proc_addr_t'($urandom()), '0);
      await_reply(RSP_FORK_DONE, thread_id_t'(i));
    end
    // one more than fits, full table reports slot 0
    send_msg(MSG_FORK, '0, proc_addr_t'($urandom()), '0);
    await_reply(RSP_TABLE_FULL, '0);
  endtask

  // credits spent, dispatch must stall
  task automatic test_credit_stall();
    await_dispatches(DISPATCH_CREDITS);
    repeat (STALL_CYCLES) begin
      @(posedge clk);
      check_value("dispatch count", disp_count, DISPATCH_CREDITS);
    end
  endtask

  // each returned credit buys exactly one dispatch
  task automatic test_credit_return(input int rounds);
    int base;
    for (int r = 0; r < rounds; r++) begin
      base = disp_count;
      return_credit();
      await_dispatches(base + 1);
      repeat (4) @(posedge clk);
      check_value("dispatch count", disp_count, base + 1);
    end
  endtask

  task automatic test_cpu_rotation();
    send_msg(MSG_CPU_START, cpu_id_t'(0), '0, '0);
    send_msg(MSG_CPU_START, cpu_id_t'(2), '0, '0);
    test_credit_return(6);
    // reshuffle the running set, wakes now go to cpu 0
    send_msg(MSG_CPU_END, cpu_id_t'(0), '0, '0);
    send_msg(MSG_CPU_START, cpu_id_t'(3), '0, '0);
    send_msg(MSG_CPU_START, cpu_id_t'(1), '0, '0);
    test_credit_return(6);
  endtask

  task automatic test_stop();
    send_msg(MSG_STOP, '0, '0, thread_id_t'(2));
    await_reply(RSP_STOP_DONE, thread_id_t'(2));
    retired[2] <= 1'b1;
    // slot 2 is free now
    send_msg(MSG_STOP, '0, '0, thread_id_t'(2));
    await_reply(RSP_BAD_THREAD, thread_id_t'(2));
    test_credit_return(THREAD_SLOTS);
  endtask

`endif

/* bench/tb_cpu_dispatcher.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_dispatcher import dispatch_pkg::*; ();

  localparam int WAIT_LIMIT = 200;
  localparam int STALL_CYCLES = 40;
  localparam logic [31:0] RAND_SEED = 32'h15df;

  logic clk;
  logic rst;
  logic msg_valid;
  msg_kind_t msg_kind;
  cpu_id_t msg_cpu;
  proc_addr_t msg_addr;
  thread_id_t msg_thread;
  logic credit_return;
  logic rsp_valid;
  rsp_kind_t rsp_kind;
  thread_id_t rsp_thread;
  logic disp_valid;
  cpu_id_t disp_cpu;
  logic disp_wake;
  proc_addr_t disp_addr;
  thread_id_t disp_thread;

  // reference model of pool, table and credits
  logic [CPU_COUNT-1:0] model_active;
  cpu_id_t model_last_cpu;
  logic model_last_wake;
  logic [THREAD_SLOTS-1:0] model_valid;
  proc_addr_t model_addr [THREAD_SLOTS];
  thread_id_t model_last_slot;
  int model_credits;
  // dispatch expected on the outputs in the current cycle
  logic exp_valid;
  cpu_id_t exp_cpu;
  logic exp_wake;
  thread_id_t exp_thread;
  proc_addr_t exp_addr;
  // dispatches seen on the dut outputs
  int disp_count;
  // stopped threads, never dispatched again
  logic [THREAD_SLOTS-1:0] retired;

  // wake when someone sleeps and the last pick was no wake, or nobody runs
  function automatic logic wake_due();
    return (model_active != '1) && (!model_last_wake || model_active == '0);
  endfunction

  function automatic cpu_id_t lowest_idle_cpu();
    for (int i = 0; i < CPU_COUNT; i++) begin
      if (!model_active[i]) return cpu_id_t'(i);
    end
    return '0;
  endfunction

  // nearest running cpu after the last served one
  function automatic cpu_id_t next_active_cpu();
    cpu_id_t c;
    for (int k = 1; k <= CPU_COUNT; k++) begin
      c = cpu_id_t'((int'(model_last_cpu) + k) % CPU_COUNT);
      if (model_active[c]) return c;
    end
    return model_last_cpu;
  endfunction

  function automatic thread_id_t next_live_slot();
    thread_id_t s;
    for (int k = 1; k <= THREAD_SLOTS; k++) begin
      s = thread_id_t'((int'(model_last_slot) + k) % THREAD_SLOTS);
      if (model_valid[s]) return s;
    end
    return model_last_slot;
  endfunction

  // -1 when the table is full
  function automatic int lowest_free_slot();
    for (int i = 0; i < THREAD_SLOTS; i++) begin
      if (!model_valid[i]) return i;
    end
    return -1;
  endfunction

`include "tb_tasks.svh"

  cpu_dispatcher dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // model steps once per edge, on the same sampled inputs as the DUT
  always @(posedge clk) begin : model_step
    logic go;
    int slot;
    if (rst) begin
      model_active <= '0;
      model_last_cpu <= cpu_id_t'(CPU_COUNT - 1);
      model_last_wake <= 1'b0;
      model_valid <= '0;
      model_last_slot <= thread_id_t'(THREAD_SLOTS - 1);
      model_credits <= DISPATCH_CREDITS;
      exp_valid <= 1'b0;
      disp_count <= 0;
    end else begin
      // outputs registered at the previous edge
      check_value("disp_valid", disp_valid, exp_valid);
      if (exp_valid) begin
        check_value("disp_cpu", disp_cpu, exp_cpu);
        check_value("disp_wake", disp_wake, exp_wake);
        check_value("disp_thread", disp_thread, exp_thread);
        check_value("disp_addr", disp_addr, exp_addr);
        check_value("retired thread dispatched", retired[disp_thread], 1'b0);
      end
      if (disp_valid) begin
        disp_count <= disp_count + 1;
      end
      // a credit and a live thread give a dispatch at this edge
      go = (model_credits > 0) && (model_valid != '0);
      exp_valid <= go;
      if (go) begin
        exp_wake <= wake_due();
        exp_cpu <= wake_due() ? lowest_idle_cpu() : next_active_cpu();
        exp_thread <= next_live_slot();
        exp_addr <= model_addr[next_live_slot()];
        model_last_wake <= wake_due();
        if (!wake_due()) model_last_cpu <= next_active_cpu();
        model_last_slot <= next_live_slot();
      end
      model_credits <= model_credits - int'(go) + int'(credit_return);
      if (msg_valid) begin
        slot = lowest_free_slot();
        case (msg_kind)
          MSG_CPU_START: model_active[msg_cpu] <= 1'b1;
          MSG_CPU_END:   model_active[msg_cpu] <= 1'b0;
          MSG_STOP:      model_valid[msg_thread] <= 1'b0;
          default: begin
            if (slot >= 0) begin
              model_valid[slot] <= 1'b1;
              model_addr[slot] <= msg_addr;
            end
          end
        endcase
      end
    end
  end

  initial begin
    void'($urandom(RAND_SEED));
    rst = 1'b1;
    msg_valid = 1'b0;
    msg_kind = MSG_CPU_START;
    msg_cpu = '0;
    msg_addr = '0;
    msg_thread = '0;
    credit_return = 1'b0;
    retired = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_idle();
    test_fork_fill();
    test_credit_stall();
    test_credit_return(3);
    test_cpu_rotation();
    test_stop();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* src/cpu_dispatcher.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_dispatcher import dispatch_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  // cluster messages
  input  wire        msg_valid,
  input  msg_kind_t  msg_kind,
  input  cpu_id_t    msg_cpu,
  input  proc_addr_t msg_addr,
  input  thread_id_t msg_thread,
  // one pulse per consumed dispatch
  input  wire        credit_return,
  // fork and stop replies
  output logic       rsp_valid,
  output rsp_kind_t  rsp_kind,
  output thread_id_t rsp_thread,
  // dispatch to the cluster
  output logic       disp_valid,
  output cpu_id_t    disp_cpu,
  output logic       disp_wake,
  output proc_addr_t disp_addr,
  output thread_id_t disp_thread
);

  // ctl to pool
  logic pool_start;
  logic pool_end;
  cpu_id_t pool_cpu;
  // ctl to table
  logic tbl_fork;
  logic tbl_stop;
  proc_addr_t tbl_addr;
  thread_id_t tbl_stop_thread;
  // shared round robin step
  logic advance;
  // table to ctl
  logic tbl_done;
  logic tbl_ok;
  thread_id_t tbl_thread;
  logic runnable;
  thread_id_t next_thread;
  proc_addr_t next_addr;
  // pool to ctl
  cpu_id_t next_cpu;
  logic next_wake;

  cpu_pool pool0 (
    .clk(clk), .rst(rst),
    .start(pool_start), .start_cpu(pool_cpu),
    .stop(pool_end), .stop_cpu(pool_cpu),
    .advance(advance), .next_cpu(next_cpu), .next_wake(next_wake)
  );

  thread_table table0 (
    .clk(clk), .rst(rst),
    .fork_req(tbl_fork), .fork_addr(tbl_addr),
    .stop(tbl_stop), .stop_thread(tbl_stop_thread), .advance(advance),
    .done(tbl_done), .ok(tbl_ok), .result_thread(tbl_thread),
    .runnable(runnable), .next_thread(next_thread), .next_addr(next_addr)
  );

  dispatch_ctl ctl0 (
    .clk(clk), .rst(rst),
    .msg_valid(msg_valid), .msg_kind(msg_kind), .msg_cpu(msg_cpu),
    .msg_addr(msg_addr), .msg_thread(msg_thread), .credit_return(credit_return),
    .tbl_done(tbl_done), .tbl_ok(tbl_ok), .tbl_thread(tbl_thread),
    .runnable(runnable), .next_thread(next_thread), .next_addr(next_addr),
    .next_cpu(next_cpu), .next_wake(next_wake),
    .pool_start(pool_start), .pool_end(pool_end), .pool_cpu(pool_cpu),
    .tbl_fork(tbl_fork), .tbl_stop(tbl_stop), .tbl_addr(tbl_addr),
    .tbl_stop_thread(tbl_stop_thread), .advance(advance),
    .rsp_valid(rsp_valid), .rsp_kind(rsp_kind), .rsp_thread(rsp_thread),
    .disp_valid(disp_valid), .disp_cpu(disp_cpu), .disp_wake(disp_wake),
    .disp_addr(disp_addr), .disp_thread(disp_thread)
  );

endmodule

`default_nettype wire

/* src/dispatch_ctl.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch_ctl import dispatch_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  // message port
  input  wire        msg_valid,
  input  msg_kind_t  msg_kind,
  input  cpu_id_t    msg_cpu,
  input  proc_addr_t msg_addr,
  input  thread_id_t msg_thread,
  input  wire        credit_return,
  // thread table results
  input  wire        tbl_done,
  input  wire        tbl_ok,
  input  thread_id_t tbl_thread,
  input  wire        runnable,
  input  thread_id_t next_thread,
  input  proc_addr_t next_addr,
  // cpu pool choice
  input  cpu_id_t    next_cpu,
  input  wire        next_wake,
  // pool commands
  output logic       pool_start,
  output logic       pool_end,
  output cpu_id_t    pool_cpu,
  // table commands
  output logic       tbl_fork,
  output logic       tbl_stop,
  output proc_addr_t tbl_addr,
  output thread_id_t tbl_stop_thread,
  output logic       advance,
  // replies
  output logic       rsp_valid,
  output rsp_kind_t  rsp_kind,
  output thread_id_t rsp_thread,
  // dispatches
  output logic       disp_valid,
  output cpu_id_t    disp_cpu,
  output logic       disp_wake,
  output proc_addr_t disp_addr,
  output thread_id_t disp_thread
);

  // open credits toward the cluster
  credit_t credits;
  // outstanding table command was a fork
  logic pend_fork;
  logic can_dispatch;

  // message decode, acted on at the sampling edge
  always_comb begin
    pool_start = 1'b0;
    pool_end = 1'b0;
    tbl_fork = 1'b0;
    tbl_stop = 1'b0;
    if (msg_valid) begin
      case (msg_kind)
        MSG_CPU_START: pool_start = 1'b1;
        MSG_CPU_END:   pool_end = 1'b1;
        MSG_FORK:      tbl_fork = 1'b1;
        MSG_STOP:      tbl_stop = 1'b1;
        default:       ;
      endcase
    end
  end

  // payload fields go straight through
  assign pool_cpu = msg_cpu;
  assign tbl_addr = msg_addr;
  assign tbl_stop_thread = msg_thread;

  // a credit and a live thread make a dispatch
  assign can_dispatch = (credits != '0) && runnable;
  assign advance = can_dispatch;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= credit_t'(DISPATCH_CREDITS);
      pend_fork <= 1'b0;
      rsp_valid <= 1'b0;
      disp_valid <= 1'b0;
    end else begin
      // take one per dispatch, give one per return
      credits <= credits - credit_t'(can_dispatch) + credit_t'(credit_return);
      if (tbl_fork || tbl_stop) begin
        pend_fork <= tbl_fork;
      end
      // reply one edge after the table settles
      rsp_valid <= tbl_done;
      disp_valid <= can_dispatch;
    end
  end

  // reply payload
  always_ff @(posedge clk) begin
    if (tbl_done) begin
      rsp_thread <= tbl_thread;
      if (pend_fork) begin
        rsp_kind <= tbl_ok ? RSP_FORK_DONE : RSP_TABLE_FULL;
      end else begin
        rsp_kind <= tbl_ok ? RSP_STOP_DONE : RSP_BAD_THREAD;
      end
    end
  end

  // dispatch payload, pairs pool and table picks
  always_ff @(posedge clk) begin
    if (can_dispatch) begin
      disp_cpu <= next_cpu;
      disp_wake <= next_wake;
      disp_addr <= next_addr;
      disp_thread <= next_thread;
    end
  end

  // return with all credits home is a cluster error
  a_credit_overflow: assert property (
    @(posedge clk) disable iff (rst)
    credit_return |-> credits != credit_t'(DISPATCH_CREDITS)
  );

  // count stays in 0..DISPATCH_CREDITS
  a_credit_range: assert property (
    @(posedge clk) disable iff (rst)
    credits <= credit_t'(DISPATCH_CREDITS)
  );

endmodule

`default_nettype wire

/* src/thread_table.sv */
`timescale 1ns/1ns
`default_nettype none

module thread_table import dispatch_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  wire        fork_req,
  input  proc_addr_t fork_addr,
  input  wire        stop,
  input  thread_id_t stop_thread,
  input  wire        advance,
  output logic       done,
  output logic       ok,
  output thread_id_t result_thread,
  output logic       runnable,
  output thread_id_t next_thread,
  output proc_addr_t next_addr
);

  // slot occupancy
  logic [THREAD_SLOTS-1:0] valid;
  // start address per slot
  proc_addr_t slot_addr [THREAD_SLOTS];
  // last slot handed out for dispatch
  thread_id_t last_slot;

  logic any_free;
  thread_id_t free_slot;

  assign any_free = ~&valid;
  assign runnable = |valid;

  // lowest free slot, 0 when full
  always_comb begin
    free_slot = '0;
    for (int i = THREAD_SLOTS - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_slot = thread_id_t'(i);
      end
    end
  end

  // round robin over live slots
  always_comb begin
    thread_id_t cand;
    next_thread = last_slot;
    // nearest live slot after last_slot wins
    // a single live slot may repeat
    for (int i = THREAD_SLOTS; i >= 1; i--) begin
      cand = last_slot + thread_id_t'(i);
      if (valid[cand]) begin
        next_thread = cand;
      end
    end
  end

  assign next_addr = slot_addr[next_thread];

  // occupancy, pointer, done strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      done <= 1'b0;
      // first search starts at slot 0
      last_slot <= '1;
    end else begin
      done <= fork_req | stop;
      if (fork_req && any_free) begin
        valid[free_slot] <= 1'b1;
      end
      if (stop) begin
        valid[stop_thread] <= 1'b0;
      end
      if (advance) begin
        last_slot <= next_thread;
      end
    end
  end

  // address store and outcome, qualified by done
  always_ff @(posedge clk) begin
    if (fork_req) begin
      ok <= any_free;
      // full table reports slot 0
      result_thread <= free_slot;
      if (any_free) begin
        slot_addr[free_slot] <= fork_addr;
      end
    end else if (stop) begin
      // stopping a free slot is reported, not fatal
      ok <= valid[stop_thread];
      result_thread <= stop_thread;
    end
  end

  // one fork or stop outstanding at a time
  a_one_cmd: assert property (
    @(posedge clk) disable iff (rst)
    !(fork_req && stop)
  );

endmodule

`default_nettype wire

/* src/cpu_pool.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_pool import dispatch_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  input  wire     start,
  input  cpu_id_t start_cpu,
  input  wire     stop,
  input  cpu_id_t stop_cpu,
  input  wire     advance,
  output cpu_id_t next_cpu,
  output logic    next_wake
);

  // one bit per cpu, set while it runs
  logic [CPU_COUNT-1:0] active;
  // last active cpu served by rotation
  cpu_id_t last_cpu;
  // previous dispatch was a wake
  logic last_wake;

  logic any_active;
  logic any_inactive;
  cpu_id_t wake_cpu;
  cpu_id_t rot_cpu;

  assign any_active = |active;
  assign any_inactive = ~&active;

  // lowest inactive cpu
  always_comb begin
    wake_cpu = '0;
    // descending scan, lowest hit wins
    for (int i = CPU_COUNT - 1; i >= 0; i--) begin
      if (!active[i]) begin
        wake_cpu = cpu_id_t'(i);
      end
    end
  end

  // next active cpu after last_cpu, wrapping
  always_comb begin
    cpu_id_t cand;
    rot_cpu = last_cpu;
    // farthest first so the nearest one is kept
    // offset CPU_COUNT wraps back to last_cpu itself
    for (int i = CPU_COUNT; i >= 1; i--) begin
      cand = last_cpu + cpu_id_t'(i);
      if (active[cand]) begin
        rot_cpu = cand;
      end
    end
  end

  // wake and rotate take turns
  // with nobody running a wake is the only choice
  assign next_wake = any_inactive && (!last_wake || !any_active);
  assign next_cpu = next_wake ? wake_cpu : rot_cpu;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= '0;
      // first rotation lands on cpu 0
      last_cpu <= '1;
      last_wake <= 1'b0;
    end else begin
      if (start) begin
        active[start_cpu] <= 1'b1;
      end
      if (stop) begin
        active[stop_cpu] <= 1'b0;
      end
      // commit the choice on dispatch
      if (advance) begin
        last_wake <= next_wake;
        // rotation pointer only moves on a served active cpu
        if (!next_wake) begin
          last_cpu <= rot_cpu;
        end
      end
    end
  end

  // cluster reports a start only for a woken, idle cpu
  a_start_idle: assert property (
    @(posedge clk) disable iff (rst)
    start |-> !active[start_cpu]
  );

endmodule

`default_nettype wire

/* src/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

  // cluster size
  localparam int CPU_COUNT = 4;

  // thread table depth
  localparam int THREAD_SLOTS = 8;

  // dispatch credits granted by the cluster out of reset
  localparam int DISPATCH_CREDITS = 4;

  // thread start address width
  localparam int ADDR_W = 32;

  // derived index widths
  localparam int CPU_ID_W = (CPU_COUNT > 1) ? $clog2(CPU_COUNT) : 1;
  localparam int THREAD_ID_W = (THREAD_SLOTS > 1) ? $clog2(THREAD_SLOTS) : 1;
  // counter must hold the full credit value itself
  localparam int CREDIT_W = $clog2(DISPATCH_CREDITS + 1);

  typedef logic [CPU_ID_W-1:0] cpu_id_t;
  typedef logic [THREAD_ID_W-1:0] thread_id_t;
  typedef logic [ADDR_W-1:0] proc_addr_t;
  typedef logic [CREDIT_W-1:0] credit_t;

  // messages from the cluster
  typedef enum logic [1:0] {
    MSG_CPU_START = 2'd0,
    MSG_CPU_END   = 2'd1,
    MSG_FORK      = 2'd2,
    MSG_STOP      = 2'd3
  } msg_kind_t;

  // replies to fork and stop
  typedef enum logic [1:0] {
    RSP_FORK_DONE  = 2'd0,
    RSP_STOP_DONE  = 2'd1,
    RSP_TABLE_FULL = 2'd2,
    RSP_BAD_THREAD = 2'd3
  } rsp_kind_t;

endpackage

`default_nettype wire
